/* ppu_pkg.sv */
`default_nettype none

package ppu_pkg;

  // Visible screen size in pixels
  localparam int screen_width  = 160;
  localparam int screen_height = 144;

  // Line and frame timing in dots and lines
  localparam int dots_per_line   = 456;
  localparam int oam_scan_dots   = 80;
  localparam int lines_per_frame = 154;

  // Video RAM geometry, addresses are relative to 0x8000
  localparam int vram_addr_bits = 13;
  localparam int vram_bytes     = 1 << vram_addr_bits;

  // STAT style mode encoding
  typedef enum logic [1:0] {
    mode_hblank   = 2'd0,
    mode_vblank   = 2'd1,
    mode_oam_scan = 2'd2,
    mode_draw     = 2'd3
  } ppu_mode_t;

  // Background fetcher stages
  typedef enum logic [1:0] {
    fetch_tile,
    fetch_low,
    fetch_high,
    fetch_push
  } fetch_state_t;

  // LCDC bit 3 bg map, bit 4 tile data mode, bit 5 window on, bit 6 window map
  typedef struct packed {
    logic [7:0] lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] wy;
    logic [7:0] wx;
  } ppu_regs_t;

  typedef struct packed {
    ppu_mode_t  mode;
    logic [7:0] ly;
    logic [8:0] dot;
  } line_pos_t;

  typedef struct packed {
    logic [vram_addr_bits-1:0] addr;
    logic [7:0]                wdata;
    logic                      write;
  } vram_req_t;

  typedef struct packed {
    logic [vram_addr_bits-1:0] addr;
    logic [7:0]                data;
  } host_wr_t;

  // One row of eight pixels, bit 7 is the leftmost pixel
  typedef struct packed {
    logic [7:0] low;
    logic [7:0] high;
  } tile_row_t;

  typedef struct packed {
    logic [1:0] color;
    logic [7:0] x;
    logic [7:0] y;
  } lcd_pixel_t;

endpackage

`default_nettype wire

/* vram.sv */
`timescale 1ns/1ps
`default_nettype none

module vram import ppu_pkg::*; (
  input  logic      clk,
  input  logic      ram_en,
  input  vram_req_t ram_req,
  output logic [7:0] rdata
);

  logic [7:0] mem [vram_bytes];

  // Single port, read data valid the cycle after the request
  always_ff @(posedge clk) begin
    if (ram_en) begin
      if (ram_req.write) begin
        mem[ram_req.addr] <= ram_req.wdata;
      end else begin
        rdata <= mem[ram_req.addr];
      end
    end
  end

endmodule

`default_nettype wire

/* vram_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module vram_arbiter import ppu_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      fetch_req,
  input  logic [vram_addr_bits-1:0] fetch_addr,
  input  host_wr_t                  host_wr,
  input  logic                      host_wr_valid,
  output logic                      host_wr_ready,
  output logic                      ram_en,
  output vram_req_t                 ram_req
);

  logic host_grant;
  // Owner of the previous RAM cycle, high when it was a host write
  logic granted_write;

  // Fetcher always wins, the host only gets idle cycles
  assign host_wr_ready = !fetch_req;
  assign host_grant    = host_wr_valid && !fetch_req;
  assign ram_en        = fetch_req || host_wr_valid;

  always_comb begin
    ram_req.addr  = fetch_req ? fetch_addr : host_wr.addr;
    ram_req.wdata = host_wr.data;
    ram_req.write = host_grant;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      granted_write <= 1'b0;
    end else begin
      granted_write <= host_grant;
    end
  end

endmodule

`default_nettype wire

/* line_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_timer import ppu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      line_done,
  output line_pos_t line_pos
);

  logic [8:0] next_dot;
  logic [7:0] next_ly;
  ppu_mode_t  next_mode;

  always_comb begin
    next_dot = line_pos.dot + 9'd1;
    next_ly  = line_pos.ly;
    // Wrap dot at end of line, ly at end of frame
    if (line_pos.dot == 9'(dots_per_line - 1)) begin
      next_dot = '0;
      if (line_pos.ly == 8'(lines_per_frame - 1)) begin
        next_ly = '0;
      end else begin
        next_ly = line_pos.ly + 8'd1;
      end
    end
    // Vblank lines hold mode 1 for the whole line
    if (next_ly >= 8'(screen_height)) begin
      next_mode = mode_vblank;
    end else if (next_dot == '0) begin
      next_mode = mode_oam_scan;
    end else if (next_dot == 9'(oam_scan_dots)) begin
      next_mode = mode_draw;
    end else if (line_pos.mode == mode_draw && line_done) begin
      // Drawing length depends on the FIFO, hblank pads the rest
      next_mode = mode_hblank;
    end else begin
      next_mode = line_pos.mode;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      line_pos.mode <= mode_oam_scan;
      line_pos.ly   <= '0;
      line_pos.dot  <= '0;
    end else begin
      line_pos.mode <= next_mode;
      line_pos.ly   <= next_ly;
      line_pos.dot  <= next_dot;
    end
  end

endmodule

`default_nettype wire

/* bg_fetcher.sv */
`timescale 1ns/1ps
`default_nettype none

module bg_fetcher import ppu_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  ppu_regs_t                 regs,
  input  line_pos_t                 line_pos,
  output logic                      fetch_req,
  output logic [vram_addr_bits-1:0] fetch_addr,
  input  logic [7:0]                vram_rdata,
  input  logic                      fifo_empty,
  output logic                      push,
  output tile_row_t                 push_row
);

  // Enough tiles for 160 pixels plus up to 7 fine scroll pixels
  localparam logic [4:0] last_col = 5'(screen_width / 8);

  fetch_state_t state;
  logic         phase;
  logic [4:0]   fetch_col;
  logic [7:0]   win_line;
  logic         win_drawn;
  logic [2:0]   row_sel;

  logic signed [8:0] win_x_signed;
  logic [7:0]        win_x_start;
  logic [4:0]        win_start_tile;
  logic              win_visible;
  logic              win_active;
  logic [4:0]        map_col;
  logic [4:0]        map_x;
  logic [7:0]        map_y;
  logic [vram_addr_bits-1:0] map_addr;
  logic [vram_addr_bits-1:0] tile_addr;

  logic start_line;
  logic active;
  logic can_push;
  logic issue_map;
  logic latch_tile;
  logic latch_low;
  logic latch_high;

  // Window origin on screen, max(0, wx - 7)
  assign win_x_signed   = $signed({1'b0, regs.wx}) - 9'sd7;
  assign win_x_start    = win_x_signed[8] ? 8'd0 : win_x_signed[7:0];
  assign win_start_tile = 5'((9'(win_x_start) + 9'd7) >> 3);
  assign win_visible    = regs.lcdc[5] && (line_pos.ly >= regs.wy) &&
                          (win_x_signed < $signed(9'(screen_width)));

  // Column of the next map read, first column is issued from mode 2
  assign map_col    = start_line ? 5'd0 : fetch_col + 5'd1;
  assign win_active = win_visible && ({map_col, 3'b000} >= win_x_start);
  assign map_x      = win_active ? map_col - win_start_tile : regs.scx[7:3] + map_col;
  assign map_y      = win_active ? win_line : regs.scy + line_pos.ly;
  // Maps sit at 0x9800 or 0x9C00
  assign map_addr   = {2'b11, win_active ? regs.lcdc[6] : regs.lcdc[3], map_y[7:3], map_x};

  // Signed mode puts tiles 0 to 127 at 0x9000, unsigned mode starts at 0x8000
  assign tile_addr = {~regs.lcdc[4] & ~vram_rdata[7], vram_rdata, row_sel, 1'b0};

  assign start_line = line_pos.mode == mode_oam_scan &&
                      line_pos.dot == 9'(oam_scan_dots - 1);
  assign active     = line_pos.mode == mode_draw && fetch_col <= last_col;
  assign can_push   = active && state == fetch_push && fifo_empty;
  assign issue_map  = start_line || (can_push && fetch_col != last_col);
  // Data arrives in phase 1, the next request goes out with it
  assign latch_tile = active && state == fetch_tile && phase;
  assign latch_low  = active && state == fetch_low && phase;
  assign latch_high = active && state == fetch_high && phase;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= fetch_tile;
      phase     <= 1'b0;
      fetch_col <= '0;
      fetch_req <= 1'b0;
      push      <= 1'b0;
      win_line  <= '0;
      win_drawn <= 1'b0;
    end else begin
      // Request is high in phase 0 of each read stage
      fetch_req <= issue_map || latch_tile || latch_low;
      push      <= can_push;
      if (start_line) begin
        state     <= fetch_tile;
        phase     <= 1'b0;
        fetch_col <= '0;
        if (win_visible) begin
          win_drawn <= 1'b1;
        end
      end else if (active) begin
        unique case (state)
          fetch_tile: begin
            phase <= ~phase;
            if (phase) state <= fetch_low;
          end
          fetch_low: begin
            phase <= ~phase;
            if (phase) state <= fetch_high;
          end
          fetch_high: begin
            phase <= ~phase;
            if (phase) state <= fetch_push;
          end
          fetch_push: begin
            // Retry every dot until the FIFO drains
            if (fifo_empty) begin
              state     <= fetch_tile;
              fetch_col <= fetch_col + 5'd1;
            end
          end
        endcase
      end
      // Window line counter restarts each frame
      if (line_pos.mode == mode_vblank) begin
        win_line  <= '0;
        win_drawn <= 1'b0;
      end else if (line_pos.dot == 9'(dots_per_line - 1) && win_drawn) begin
        win_line  <= win_line + 8'd1;
        win_drawn <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue_map) begin
      fetch_addr <= map_addr;
      row_sel    <= map_y[2:0];
    end else if (latch_tile) begin
      fetch_addr <= tile_addr;
    end else if (latch_low) begin
      // High byte follows the low byte
      fetch_addr   <= {fetch_addr[vram_addr_bits-1:1], 1'b1};
      push_row.low <= vram_rdata;
    end
    if (latch_high) begin
      push_row.high <= vram_rdata;
    end
  end

endmodule

`default_nettype wire

/* bg_pixel_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module bg_pixel_fifo import ppu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  line_pos_t  line_pos,
  input  logic [2:0] scx_fine,
  input  logic       push,
  input  tile_row_t  push_row,
  output logic       empty,
  output logic       line_done,
  output logic       pixel_valid,
  output lcd_pixel_t pixel
);

  tile_row_t  shift_row;
  logic [3:0] count;
  logic [2:0] discard;
  logic [7:0] x_pos;
  logic       line_full;
  logic       shift;
  logic       emit;

  assign empty     = count == 4'd0;
  assign line_full = x_pos == 8'(screen_width);
  // One pixel per dot while drawing, stop after the last visible one
  assign shift     = line_pos.mode == mode_draw && !empty && !line_full;
  // Fine scroll pixels leave the FIFO but never reach the screen
  assign emit      = shift && discard == 3'd0;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count       <= '0;
      discard     <= '0;
      x_pos       <= '0;
      pixel_valid <= 1'b0;
      line_done   <= 1'b0;
    end else begin
      pixel_valid <= emit;
      line_done   <= emit && x_pos == 8'(screen_width - 1);
      if (line_pos.mode == mode_oam_scan) begin
        count   <= '0;
        x_pos   <= '0;
        discard <= scx_fine;
      end else if (push) begin
        count <= 4'd8;
      end else if (shift) begin
        count <= count - 4'd1;
        if (discard != 3'd0) begin
          discard <= discard - 3'd1;
        end else begin
          x_pos <= x_pos + 8'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      shift_row <= push_row;
    end else if (shift) begin
      shift_row.low  <= {shift_row.low[6:0], 1'b0};
      shift_row.high <= {shift_row.high[6:0], 1'b0};
    end
    // Colour is high plane bit over low plane bit
    if (emit) begin
      pixel.color <= {shift_row.high[7], shift_row.low[7]};
      pixel.x     <= x_pos;
      pixel.y     <= line_pos.ly;
    end
  end

endmodule

`default_nettype wire

/* ppu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_top import ppu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  ppu_regs_t  regs,
  input  host_wr_t   host_wr,
  input  logic       host_wr_valid,
  output logic       host_wr_ready,
  output logic       pixel_valid,
  output lcd_pixel_t pixel,
  output line_pos_t  line_pos
);

  logic                      line_done;
  logic                      fetch_req;
  logic [vram_addr_bits-1:0] fetch_addr;
  logic [7:0]                vram_rdata;
  logic                      fifo_empty;
  logic                      push;
  tile_row_t                 push_row;
  logic                      ram_en;
  vram_req_t                 ram_req;

  line_timer u_line_timer (
    .clk       (clk),
    .reset     (reset),
    .line_done (line_done),
    .line_pos  (line_pos)
  );

  bg_fetcher u_bg_fetcher (
    .clk        (clk),
    .reset      (reset),
    .regs       (regs),
    .line_pos   (line_pos),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .vram_rdata (vram_rdata),
    .fifo_empty (fifo_empty),
    .push       (push),
    .push_row   (push_row)
  );

  // Fine scroll is the low three bits of scx
  bg_pixel_fifo u_bg_pixel_fifo (
    .clk         (clk),
    .reset       (reset),
    .line_pos    (line_pos),
    .scx_fine    (regs.scx[2:0]),
    .push        (push),
    .push_row    (push_row),
    .empty       (fifo_empty),
    .line_done   (line_done),
    .pixel_valid (pixel_valid),
    .pixel       (pixel)
  );

  vram_arbiter u_vram_arbiter (
    .clk           (clk),
    .reset         (reset),
    .fetch_req     (fetch_req),
    .fetch_addr    (fetch_addr),
    .host_wr       (host_wr),
    .host_wr_valid (host_wr_valid),
    .host_wr_ready (host_wr_ready),
    .ram_en        (ram_en),
    .ram_req       (ram_req)
  );

  vram u_vram (
    .clk     (clk),
    .ram_en  (ram_en),
    .ram_req (ram_req),
    .rdata   (vram_rdata)
  );

endmodule

`default_nettype wire

/* ppu_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_sva import ppu_pkg::*; (
  input logic                      clk,
  input logic                      reset,
  input logic                      fetch_req,
  input logic [vram_addr_bits-1:0] fetch_addr,
  input fetch_state_t              fetch_state,
  input logic                      fetch_phase,
  input logic                      ram_en,
  input vram_req_t                 ram_req,
  input logic                      granted_write,
  input host_wr_t                  host_wr,
  input logic                      host_wr_valid,
  input logic                      host_wr_ready,
  input line_pos_t                 line_pos,
  input logic                      pixel_valid
);

  // Stalled host write keeps its payload
  a_host_hold: assert property (@(posedge clk) disable iff (reset)
    host_wr_valid && !host_wr_ready |=> host_wr_valid && $stable(host_wr))
    else $error("host write changed while stalled");

  // Fetcher always owns the RAM port, host held off
  a_fetch_priority: assert property (@(posedge clk) disable iff (reset)
    fetch_req |-> !host_wr_ready && ram_en && !ram_req.write &&
      ram_req.addr == fetch_addr)
    else $error("fetcher did not own the RAM port");

  // Latched byte comes from the fetcher's own read, never after a host write
  a_read_source: assert property (@(posedge clk) disable iff (reset)
    line_pos.mode == mode_draw && fetch_state != fetch_push && fetch_phase |->
      $past(fetch_req) && !granted_write)
    else $error("fetcher latched data not from its own read");

  // Drawing starts at dot 80
  a_draw_start: assert property (@(posedge clk) disable iff (reset)
    line_pos.mode == mode_draw && $past(line_pos.mode) != mode_draw |->
      line_pos.dot == 9'(oam_scan_dots))
    else $error("drawing started off dot 80");

  // Legal steps 2 to 3 to 0 inside a line
  a_oam_next: assert property (@(posedge clk) disable iff (reset)
    line_pos.mode == mode_oam_scan |=>
      line_pos.mode == mode_oam_scan || line_pos.mode == mode_draw)
    else $error("bad mode after scan");

  a_draw_next: assert property (@(posedge clk) disable iff (reset)
    line_pos.mode == mode_draw |=>
      line_pos.mode == mode_draw || line_pos.mode == mode_hblank)
    else $error("bad mode after drawing");

  a_hblank_next: assert property (@(posedge clk) disable iff (reset)
    line_pos.mode == mode_hblank |=> line_pos.mode == mode_hblank ||
      line_pos.mode == mode_vblank ||
      (line_pos.mode == mode_oam_scan && line_pos.dot == 9'd0))
    else $error("bad mode after hblank");

  // Mode 1 on exactly the vblank lines
  a_vblank_lines: assert property (@(posedge clk) disable iff (reset)
    (line_pos.mode == mode_vblank) == (line_pos.ly >= 8'(screen_height)))
    else $error("vblank mode on wrong line");

  a_ly_wrap: assert property (@(posedge clk) disable iff (reset)
    line_pos.ly == 8'(lines_per_frame - 1) && line_pos.dot == 9'(dots_per_line - 1)
      |=> line_pos.ly == 8'd0)
    else $error("ly did not wrap to 0");

  a_pixel_in_draw: assert property (@(posedge clk) disable iff (reset)
    pixel_valid |-> line_pos.mode == mode_draw)
    else $error("pixel outside drawing");

  a_pixel_reset: assert property (@(posedge clk) reset |-> !pixel_valid)
    else $error("pixel valid during reset");

endmodule

bind ppu_top ppu_sva u_ppu_sva (
  .clk           (clk),
  .reset         (reset),
  .fetch_req     (fetch_req),
  .fetch_addr    (fetch_addr),
  .fetch_state   (u_bg_fetcher.state),
  .fetch_phase   (u_bg_fetcher.phase),
  .ram_en        (ram_en),
  .ram_req       (ram_req),
  .granted_write (u_vram_arbiter.granted_write),
  .host_wr       (host_wr),
  .host_wr_valid (host_wr_valid),
  .host_wr_ready (host_wr_ready),
  .line_pos      (line_pos),
  .pixel_valid   (pixel_valid)
);

`default_nettype wire

/* tb_ppu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ppu import ppu_pkg::*; ();

  logic       clk;
  logic       reset;
  ppu_regs_t  regs;
  host_wr_t   host_wr;
  logic       host_wr_valid;
  logic       host_wr_ready;
  logic       pixel_valid;
  lcd_pixel_t pixel;
  line_pos_t  line_pos;

  // Reference copy of every byte written
  logic [7:0]  mem_model [vram_bytes];
  logic [31:0] lcg_state;
  logic        check_en;
  int          exp_x;
  // Window line count as seen from the screen
  int          win_count;
  logic        cur_win;

  ppu_top uut (
    .clk           (clk),
    .reset         (reset),
    .regs          (regs),
    .host_wr       (host_wr),
    .host_wr_valid (host_wr_valid),
    .host_wr_ready (host_wr_ready),
    .pixel_valid   (pixel_valid),
    .pixel         (pixel),
    .line_pos      (line_pos)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input int expected, input int actual);
    abort_run($sformatf("MISMATCH %s expected %0h actual %0h", name, expected, actual));
  endtask

  // Unsigned from 0x8000, or signed around 0x9000 when lcdc bit 4 is clear
  function automatic logic [12:0] data_addr(input logic [7:0] tile, input logic [2:0] row);
    logic [12:0] base;
    if (regs.lcdc[4] || tile[7]) begin
      base = {1'b0, tile, 4'b0000};
    end else begin
      base = 13'h1000 + {1'b0, tile, 4'b0000};
    end
    return base + {9'd0, row, 1'b0};
  endfunction

  function automatic logic [1:0] expected_color(input int x, input int y);
    int          col;
    int          row;
    int          fine;
    int          px;
    int          wxs;
    logic [12:0] map_base;
    logic [12:0] row_addr;
    logic [7:0]  tile;
    wxs = int'(regs.wx) - 7;
    if (cur_win && x >= wxs) begin
      // Window tiles count from the window's left edge
      col      = (x - wxs) / 8;
      row      = win_count / 8;
      fine     = win_count % 8;
      px       = (x - wxs) % 8;
      map_base = regs.lcdc[6] ? 13'h1c00 : 13'h1800;
    end else begin
      col      = ((int'(regs.scx) + x) / 8) % 32;
      row      = ((int'(regs.scy) + y) % 256) / 8;
      fine     = (int'(regs.scy) + y) % 8;
      px       = (int'(regs.scx) + x) % 8;
      map_base = regs.lcdc[3] ? 13'h1c00 : 13'h1800;
    end
    tile     = mem_model[map_base + 13'(row * 32 + col)];
    row_addr = data_addr(tile, 3'(fine));
    // High plane gives the upper colour bit
    return {mem_model[row_addr + 13'd1][3'(7 - px)], mem_model[row_addr][3'(7 - px)]};
  endfunction

  // Pixel and line checks, sampled away from the driving edge
  always @(negedge clk) begin
    if (line_pos.dot == 9'd0) begin
      if (check_en && line_pos.ly != 8'd0 && line_pos.ly <= 8'(screen_height)) begin
        assert (exp_x == screen_width)
          else report_mismatch("pixel.x count", screen_width, exp_x);
      end
      if (cur_win) begin
        win_count = win_count + 1;
      end
      cur_win = 1'b0;
      exp_x   = 0;
    end
    if (line_pos.mode == mode_vblank) begin
      win_count = 0;
    end
    if (line_pos.mode == mode_draw && line_pos.dot == 9'(oam_scan_dots)) begin
      cur_win = regs.lcdc[5] && line_pos.ly >= regs.wy && regs.wx < 8'd167;
    end
    if (pixel_valid && check_en) begin
      assert (pixel.x == 8'(exp_x)) else report_mismatch("pixel.x", exp_x, int'(pixel.x));
      assert (pixel.y == line_pos.ly)
        else report_mismatch("pixel.y", int'(line_pos.ly), int'(pixel.y));
      assert (pixel.color == expected_color(exp_x, int'(line_pos.ly)))
        else report_mismatch("pixel.color", int'(expected_color(exp_x, int'(line_pos.ly))),
                             int'(pixel.color));
      exp_x = exp_x + 1;
    end
  end

  task automatic wait_pos(input logic [7:0] ly, input ppu_mode_t mode);
    int wait_cycles;
    wait_cycles = 0;
    @(negedge clk);
    while (!(line_pos.ly == ly && line_pos.mode == mode)) begin
      wait_cycles++;
      if (wait_cycles > 200000) begin
        abort_run("timeout waiting for a line position");
      end
      @(negedge clk);
    end
  endtask

  task automatic host_write(input logic [12:0] addr, input logic [7:0] data);
    int wait_cycles;
    wait_cycles = 0;
    @(posedge clk);
    host_wr       <= '{addr: addr, data: data};
    host_wr_valid <= 1'b1;
    @(negedge clk);
    // Stalled while the fetcher reads
    while (!host_wr_ready) begin
      wait_cycles++;
      if (wait_cycles > 1000) begin
        abort_run("host write was never accepted");
      end
      @(negedge clk);
    end
    @(posedge clk);
    mem_model[addr] = data;
    host_wr_valid <= 1'b0;
  endtask

  // Tile data mode and bg map from the frame number, window from frame 4 on
  task automatic set_frame_regs(input int f);
    logic [31:0] r1;
    logic [31:0] r2;
    ppu_regs_t   new_regs;
    r1            = next_random();
    r2            = next_random();
    new_regs.lcdc = {1'b1, r1[0], f >= 4, f[1], f[0], 3'b000};
    new_regs.scy  = r1[15:8];
    new_regs.scx  = r1[23:16];
    new_regs.wy   = 8'(r2[15:0] % 16'd144);
    new_regs.wx   = 8'd7 + 8'd8 * 8'(r2[23:16] % 8'd20);
    // Window frames use whole-tile scroll
    if (f >= 4) begin
      new_regs.scx[2:0] = 3'd0;
    end
    @(posedge clk);
    regs <= new_regs;
  endtask

  initial begin
    logic [31:0] rnd;
    lcg_state     = 32'h5873e001;
    reset         = 1'b1;
    regs          = '0;
    host_wr       = '0;
    host_wr_valid = 1'b0;
    check_en      = 1'b0;
    exp_x         = 0;
    win_count     = 0;
    cur_win       = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // Random tiles and maps over the whole RAM
    for (int a = 0; a < vram_bytes; a++) begin
      rnd = next_random();
      host_write(13'(a), rnd[23:16]);
    end
    for (int f = 0; f < 8; f++) begin
      wait_pos(8'd145, mode_vblank);
      set_frame_regs(f);
      check_en = 1'b1;
      for (int l = 0; l < screen_height; l++) begin
        rnd = next_random();
        wait_pos(8'(l), mode_draw);
        // Writes into the idle map, shown once lcdc bit 3 flips
        if (!regs.lcdc[5] && rnd[20]) begin
          host_write((regs.lcdc[3] ? 13'h1800 : 13'h1c00) + 13'(rnd[9:0]), rnd[31:24]);
        end
        wait_pos(8'(l), mode_hblank);
        // Window switched per line, counter must skip those lines
        if (f == 5) begin
          @(posedge clk);
          regs.lcdc[5] <= rnd[3];
        end
      end
    end
    wait_pos(8'd145, mode_vblank);
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
ppu_pkg.sv
vram.sv
vram_arbiter.sv
line_timer.sv
bg_fetcher.sv
bg_pixel_fifo.sv
ppu_top.sv
ppu_sva.sv
tb_ppu.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module tb_ppu -f build.f -o tb_ppu
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed"
  exit $status
fi

./obj_dir/tb_ppu
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
fi
exit $status
